// ==== pgwr_cfg_pkg.sv ====
// address map, table sizes and bus widths of the page-table write manager
// tables must sit 64-byte aligned; sizes are cut down (16 ATT, 8 list entries)
// lines are written in natural byte order, no endian swap
package pgwr_cfg_pkg;

	typedef logic [63:0]  addr_t; // byte address
	typedef logic [511:0] line_t; // one cache line
	typedef logic [63:0]  strb_t; // byte strobes of a line

	// memory map
	localparam addr_t ATT_BASE  = 64'h0000_0000_8000_0000;
	localparam addr_t LIST_BASE = 64'h0000_0000_8000_1000; // right after the ATT page

	// first physical page handed out by list init
	localparam logic [39:0] PPA_PAGE_BASE = 40'h00_0008_0100;

	// table sizes
	localparam int unsigned ATT_ENTRY_CNT  = 16;
	localparam int unsigned LIST_ENTRY_CNT = 8;

	// line geometry
	localparam int unsigned LINE_BYTES   = 64;
	localparam int unsigned ATT_PER_LINE = 8; // 64-bit ATT entries
	localparam int unsigned LST_PER_LINE = 4; // 128-bit list entries

	// write response side
	localparam int unsigned CNT_W     = 7;     // up to 127 responses outstanding
	localparam logic [1:0]  RESP_OKAY = 2'b00;

endpackage

// ==== pgwr_tbl_pkg.sv ====
// table entry formats, list and status codes, command kinds and sequencer steps
// id 0 is null for both ATT ids and list pointers, entries count from 1
package pgwr_tbl_pkg;

	typedef logic [4:0]  att_id_t;  // ATT entry id
	typedef logic [31:0] lst_id_t;  // list pointer
	typedef logic [39:0] way_t;     // page number
	typedef logic [1:0]  list_sel_t;
	typedef logic [1:0]  sts_t;
	typedef logic [1:0]  cmd_kind_t;

	// list codes, only free and uncompressed are handled
	localparam list_sel_t FREE   = 2'd0;
	localparam list_sel_t UNCOMP = 2'd1;

	// ATT status codes
	localparam sts_t DALLOC     = 2'd0;
	localparam sts_t UNCOMP_STS = 2'd1;

	// command kinds
	localparam cmd_kind_t CMD_NONE      = 2'd0;
	localparam cmd_kind_t CMD_ATT_INIT  = 2'd1;
	localparam cmd_kind_t CMD_LIST_INIT = 2'd2;
	localparam cmd_kind_t CMD_UPDATE    = 2'd3;

	// ATT entry, 64 bits; zero-page count above bit 41 is always written 0
	localparam int unsigned ATT_ENTRY_W = 64;
	localparam int unsigned ATT_STS_LSB = 0;
	localparam int unsigned ATT_WAY_LSB = 2;

	// list entry, 128 bits, zero above the way
	localparam int unsigned LST_ENTRY_W  = 128;
	localparam int unsigned LST_NEXT_LSB = 0;
	localparam int unsigned LST_PREV_LSB = 32;
	localparam int unsigned LST_WAY_LSB  = 64;

	// sequencer steps, shared with the line builder
	typedef enum logic [2:0] {
		ST_IDLE,
		ST_INIT_ATT,
		ST_INIT_LIST,
		ST_ATT_UPD,   // allocate ATT entry
		ST_POP,       // unlink head of free list
		ST_PUSH_SELF, // new tail entry
		ST_PUSH_LINK, // old tail points to new tail
		ST_DRAIN      // wait for all responses
	} seq_state_t;

endpackage

// ==== pgwr_cmd_if.sv ====
// command handoff from the intake to the sequencer
// start is a single-cycle pulse, the fields stay valid until the next start
`timescale 1ns/1ps

interface pgwr_cmd_if
	import pgwr_tbl_pkg::*;
();

	logic      start;    // one-cycle pulse
	cmd_kind_t kind;     // still valid at finish
	att_id_t   att_id;
	lst_id_t   tol_id;
	list_sel_t src_list;
	list_sel_t dst_list;
	way_t      way;
	lst_id_t   prev;
	lst_id_t   next;
	logic      idle;     // level
	logic      finish;   // one-cycle pulse

	modport intake (
		output start, kind, att_id, tol_id, src_list, dst_list, way, prev, next,
		input  idle, finish
	);

	modport seq (
		input  start, kind, att_id, tol_id, src_list, dst_list, way, prev, next,
		output idle, finish
	);

endinterface

// ==== pgwr_beat_if.sv ====
// one table write from the sequencer to the AXI port
// addr, data and strb are only sampled in the issue cycle
`timescale 1ns/1ps

interface pgwr_beat_if
	import pgwr_cfg_pkg::*;
();

	logic  issue;    // one-cycle pulse
	addr_t addr;     // line address
	line_t data;
	strb_t strb;
	logic  accepted; // pulse, W handshake done
	logic  drained;  // no response outstanding

	modport seq (
		output issue, addr, data, strb,
		input  accepted, drained
	);

	modport port (
		input  issue, addr, data, strb,
		output accepted, drained
	);

endinterface

// ==== pgwr_cmd_intake.sv ====
// request arbitration: ATT init over list init over table update
// init requests are levels, each runs once; an update pulse while busy is dropped
`timescale 1ns/1ps

module pgwr_cmd_intake
	import pgwr_tbl_pkg::*;
(
	input  logic       clk_i,
	input  logic       rst_ni,
	input  logic       init_att,
	input  logic       init_list,
	input  logic       tbl_update,
	input  att_id_t    att_entry_id,
	input  lst_id_t    tol_entry_id,
	input  list_sel_t  src_list,
	input  list_sel_t  dst_list,
	input  way_t       lst_way,
	input  lst_id_t    lst_prev,
	input  lst_id_t    lst_next,
	output logic       init_att_done,
	output logic       init_list_done,
	pgwr_cmd_if.intake cmd
);

	logic att_req;   // ATT init still pending
	logic list_req;  // list init still pending
	logic can_start; // sequencer idle, nothing launched yet
	logic upd_take;

	assign att_req   = init_att && !init_att_done;
	assign list_req  = init_list && !init_list_done;
	assign can_start = cmd.idle && !cmd.start; // idle drops one cycle after start
	assign upd_take  = can_start && !att_req && !list_req && tbl_update;

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			cmd.start      <= 1'b0;
			cmd.kind       <= CMD_NONE;
			init_att_done  <= 1'b0;
			init_list_done <= 1'b0;
		end else begin
			cmd.start <= can_start && (att_req || list_req || tbl_update);
			if (can_start && att_req) begin
				cmd.kind <= CMD_ATT_INIT;
			end else if (can_start && list_req) begin
				cmd.kind <= CMD_LIST_INIT;
			end else if (upd_take) begin
				cmd.kind <= CMD_UPDATE;
			end
			if (cmd.finish && cmd.kind == CMD_ATT_INIT) init_att_done <= 1'b1; // sticky
			if (cmd.finish && cmd.kind == CMD_LIST_INIT) init_list_done <= 1'b1;
		end
	end

	// update fields, held for the whole command
	always_ff @(posedge clk_i) begin
		if (upd_take) begin
			cmd.att_id   <= att_entry_id;
			cmd.tol_id   <= tol_entry_id;
			cmd.src_list <= src_list;
			cmd.dst_list <= dst_list;
			cmd.way      <= lst_way;
			cmd.prev     <= lst_prev;
			cmd.next     <= lst_next;
		end
	end

endmodule

// ==== pgwr_line_builder.sv ====
// forms address, data and byte strobes of the write for the current step
// one entry or one pointer field per line, everything else strobed off
// entry k lives in slot (k-1) mod per-line on line (k-1) / per-line
`timescale 1ns/1ps

module pgwr_line_builder
	import pgwr_cfg_pkg::*;
	import pgwr_tbl_pkg::*;
(
	input  cmd_kind_t  kind,
	input  seq_state_t step,
	input  att_id_t    entry_cnt,   // init walk, from 1
	input  att_id_t    att_id,
	input  lst_id_t    tol_id,
	input  way_t       way,
	input  lst_id_t    prev,
	input  lst_id_t    next,
	input  lst_id_t    uncomp_tail,
	output addr_t      addr,
	output line_t      data,
	output strb_t      strb
);

	logic        is_att;   // ATT table, else list table
	lst_id_t     id;       // entry touched by this step
	lst_id_t     idx;
	int unsigned slot;
	int unsigned ent_lsb;  // bit offset of the entry in the line
	int unsigned byte_lsb;
	addr_t       line_no;
	lst_id_t     init_next;

	assign is_att = (kind == CMD_ATT_INIT) || (step == ST_ATT_UPD);

	always_comb begin
		case (step)
			ST_ATT_UPD:   id = lst_id_t'(att_id);
			ST_POP:       id = next;        // successor of the popped head
			ST_PUSH_SELF: id = tol_id;
			ST_PUSH_LINK: id = uncomp_tail; // old tail
			default:      id = lst_id_t'(entry_cnt);
		endcase
	end

	assign idx      = id - 1'b1;
	assign slot     = is_att ? idx % ATT_PER_LINE : idx % LST_PER_LINE;
	assign line_no  = is_att ? addr_t'(idx / ATT_PER_LINE) : addr_t'(idx / LST_PER_LINE);
	assign addr     = (is_att ? ATT_BASE : LIST_BASE) + line_no * LINE_BYTES;
	assign ent_lsb  = slot * (is_att ? ATT_ENTRY_W : LST_ENTRY_W);
	assign byte_lsb = ent_lsb / 8;

	// last list entry ends the chain
	assign init_next = (entry_cnt == att_id_t'(LIST_ENTRY_CNT)) ? '0 : lst_id_t'(entry_cnt) + 1'b1;

	always_comb begin
		data = '0;
		strb = '0;
		case (step)
			ST_INIT_ATT: begin // way 0, zpd 0
				data[ent_lsb + ATT_STS_LSB +: $bits(sts_t)] = DALLOC;
				strb[byte_lsb +: ATT_ENTRY_W / 8] = '1;
			end
			ST_INIT_LIST: begin
				data[ent_lsb + LST_NEXT_LSB +: $bits(lst_id_t)] = init_next;
				data[ent_lsb + LST_PREV_LSB +: $bits(lst_id_t)] = lst_id_t'(entry_cnt) - 1'b1;
				data[ent_lsb + LST_WAY_LSB +: $bits(way_t)] = PPA_PAGE_BASE + entry_cnt - 1'b1;
				strb[byte_lsb +: LST_ENTRY_W / 8] = '1;
			end
			ST_ATT_UPD: begin
				data[ent_lsb + ATT_STS_LSB +: $bits(sts_t)] = UNCOMP_STS;
				data[ent_lsb + ATT_WAY_LSB +: $bits(way_t)] = way;
				strb[byte_lsb +: ATT_ENTRY_W / 8] = '1;
			end
			ST_POP: begin // only prev of the new head
				data[ent_lsb + LST_PREV_LSB +: $bits(lst_id_t)] = prev;
				strb[byte_lsb + 4 +: 4] = '1;
			end
			ST_PUSH_SELF: begin // next stays 0 for the tail
				data[ent_lsb + LST_PREV_LSB +: $bits(lst_id_t)] = uncomp_tail;
				strb[byte_lsb +: 8] = '1;
			end
			ST_PUSH_LINK: begin
				data[ent_lsb + LST_NEXT_LSB +: $bits(lst_id_t)] = tol_id;
				strb[byte_lsb +: 4] = '1;
			end
			default: ;
		endcase
	end

endmodule

// ==== pgwr_seq.sv ====
// processing FSM, one write per step, next issue only after W accepted
// owns free and uncompressed head/tail; only free-to-uncompressed moves
// a command finishes once every response is back
`timescale 1ns/1ps

module pgwr_seq
	import pgwr_cfg_pkg::*;
	import pgwr_tbl_pkg::*;
(
	input  logic      clk_i,
	input  logic      rst_ni,
	pgwr_cmd_if.seq   cmd,
	pgwr_beat_if.seq  beat,
	output logic      tbl_update_done,
	output lst_id_t   free_head,
	output lst_id_t   free_tail,
	output lst_id_t   uncomp_head,
	output lst_id_t   uncomp_tail
);

	seq_state_t state;
	seq_state_t after_pop; // push only into the uncompressed list
	att_id_t    entry_cnt;
	logic       busy;      // write in AW/W handshake
	logic       pop_done;

	assign after_pop = (cmd.dst_list == UNCOMP) ? ST_PUSH_SELF : ST_DRAIN;
	assign cmd.idle   = (state == ST_IDLE);
	assign cmd.finish = (state == ST_DRAIN) && beat.drained;
	assign tbl_update_done = cmd.finish && (cmd.kind == CMD_UPDATE);
	assign beat.issue = !busy && (state != ST_IDLE) && (state != ST_DRAIN);

	// pop completes on its own write, or right after the ATT write when skipped
	assign pop_done = beat.accepted &&
		((state == ST_POP) || (state == ST_ATT_UPD && cmd.next == '0));

	pgwr_line_builder line_builder_i (
		.kind        (cmd.kind),
		.step        (state),
		.entry_cnt   (entry_cnt),
		.att_id      (cmd.att_id),
		.tol_id      (cmd.tol_id),
		.way         (cmd.way),
		.prev        (cmd.prev),
		.next        (cmd.next),
		.uncomp_tail (uncomp_tail),
		.addr        (beat.addr),
		.data        (beat.data),
		.strb        (beat.strb)
	);

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			state       <= ST_IDLE;
			entry_cnt   <= '0;
			busy        <= 1'b0;
			free_head   <= '0; // null
			free_tail   <= '0;
			uncomp_head <= '0;
			uncomp_tail <= '0;
		end else begin
			if (beat.issue) busy <= 1'b1;
			else if (beat.accepted) busy <= 1'b0;
			if (pop_done && cmd.src_list == FREE) begin
				free_head <= cmd.next;
				if (cmd.next == '0) free_tail <= '0; // free list ran empty
			end
			case (state)
				ST_IDLE: if (cmd.start) begin
					entry_cnt <= att_id_t'(1);
					case (cmd.kind)
						CMD_ATT_INIT:  state <= ST_INIT_ATT;
						CMD_LIST_INIT: state <= ST_INIT_LIST;
						CMD_UPDATE:    state <= ST_ATT_UPD;
						default:       state <= ST_IDLE;
					endcase
				end
				ST_INIT_ATT: if (beat.accepted) begin
					entry_cnt <= entry_cnt + 1'b1;
					if (entry_cnt == att_id_t'(ATT_ENTRY_CNT)) state <= ST_DRAIN;
				end
				ST_INIT_LIST: if (beat.accepted) begin
					entry_cnt <= entry_cnt + 1'b1;
					if (entry_cnt == att_id_t'(LIST_ENTRY_CNT)) begin
						free_head <= lst_id_t'(1); // one long chain 1..N
						free_tail <= lst_id_t'(LIST_ENTRY_CNT);
						state     <= ST_DRAIN;
					end
				end
				ST_ATT_UPD: if (beat.accepted) begin
					state <= (cmd.next != '0) ? ST_POP : after_pop; // no successor, no pop write
				end
				ST_POP: if (beat.accepted) state <= after_pop;
				ST_PUSH_SELF: if (beat.accepted) begin
					if (uncomp_tail == '0) begin // empty list, entry is head and tail
						uncomp_head <= cmd.tol_id;
						uncomp_tail <= cmd.tol_id;
						state       <= ST_DRAIN;
					end else begin
						state <= ST_PUSH_LINK;
					end
				end
				ST_PUSH_LINK: if (beat.accepted) begin
					uncomp_tail <= cmd.tol_id; // old tail used by the link write
					state       <= ST_DRAIN;
				end
				ST_DRAIN: if (beat.drained) state <= ST_IDLE;
				default: state <= ST_IDLE;
			endcase
		end
	end

	// port accepts only the one write in flight
	a_one_in_flight: assert property (@(posedge clk_i) disable iff (!rst_ni)
		beat.accepted |-> busy)
		else $error("write accepted with no write issued and pending");

endmodule

// ==== pgwr_axi_wr_port.sv ====
// single-beat AXI writes, AW first then W, one line per write
// bready is assumed always high; responses come back in order
// bus_error is sticky: non-OKAY response or a response with none outstanding
`timescale 1ns/1ps

module pgwr_axi_wr_port
	import pgwr_cfg_pkg::*;
(
	input  logic       clk_i,
	input  logic       rst_ni,
	pgwr_beat_if.port  beat,
	output logic       awvalid,
	input  logic       awready,
	output addr_t      awaddr,
	output logic       wvalid,
	input  logic       wready,
	output line_t      wdata,
	output strb_t      wstrb,
	input  logic       bvalid,
	input  logic [1:0] bresp,
	output logic       bus_error
);

	logic [CNT_W-1:0] pending; // AW accepted, response not yet back
	logic             aw_hs;
	logic             w_hs;
	logic             b_ok;

	assign aw_hs = awvalid && awready;
	assign w_hs  = wvalid && wready;
	assign b_ok  = bvalid && (bresp == RESP_OKAY) && (pending != '0);
	assign beat.drained = (pending == '0);

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			awvalid       <= 1'b0;
			wvalid        <= 1'b0;
			beat.accepted <= 1'b0;
			pending       <= '0;
			bus_error     <= 1'b0;
		end else begin
			if (beat.issue) awvalid <= 1'b1;
			else if (aw_hs) awvalid <= 1'b0;
			if (aw_hs) wvalid <= 1'b1; // W follows the AW handshake
			else if (w_hs) wvalid <= 1'b0;
			beat.accepted <= w_hs;
			case ({aw_hs, b_ok})
				2'b10:   pending <= pending + 1'b1;
				2'b01:   pending <= pending - 1'b1;
				default: ;
			endcase
			if (bvalid && (bresp != RESP_OKAY || pending == '0)) bus_error <= 1'b1;
		end
	end

	// line payload, held until the next issue
	always_ff @(posedge clk_i) begin
		if (beat.issue) begin
			awaddr <= beat.addr;
			wdata  <= beat.data;
			wstrb  <= beat.strb;
		end
	end

	a_aw_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
		awvalid && !awready |=> awvalid && $stable(awaddr))
		else $error("AW changed while waiting for awready");

	a_w_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
		wvalid && !wready |=> wvalid && $stable(wdata) && $stable(wstrb))
		else $error("W changed while waiting for wready");

endmodule

// ==== pgwr_top.sv ====
// page-table write manager: ATT init, free-list init, table update
// one AXI write in the handshake at a time, responses may lag any number
`timescale 1ns/1ps

module pgwr_top
	import pgwr_cfg_pkg::*;
	import pgwr_tbl_pkg::*;
(
	input  logic       clk_i,
	input  logic       rst_ni,
	input  logic       init_att,
	input  logic       init_list,
	input  logic       tbl_update,
	input  att_id_t    att_entry_id,
	input  lst_id_t    tol_entry_id,
	input  list_sel_t  src_list,
	input  list_sel_t  dst_list,
	input  way_t       lst_way,
	input  lst_id_t    lst_prev,
	input  lst_id_t    lst_next,
	output logic       awvalid,
	input  logic       awready,
	output addr_t      awaddr,
	output logic       wvalid,
	input  logic       wready,
	output line_t      wdata,
	output strb_t      wstrb,
	input  logic       bvalid,
	input  logic [1:0] bresp,
	output logic       init_att_done,
	output logic       init_list_done,
	output logic       mngr_ready,
	output logic       tbl_update_done,
	output logic       bus_error,
	output lst_id_t    free_head,
	output lst_id_t    free_tail,
	output lst_id_t    uncomp_head,
	output lst_id_t    uncomp_tail
);

	pgwr_cmd_if  cmd_if ();
	pgwr_beat_if beat_if ();

	assign mngr_ready = cmd_if.idle;

	pgwr_cmd_intake cmd_intake_i (
		.clk_i, .rst_ni, .init_att, .init_list, .tbl_update,
		.att_entry_id, .tol_entry_id, .src_list, .dst_list,
		.lst_way, .lst_prev, .lst_next,
		.init_att_done, .init_list_done,
		.cmd (cmd_if.intake)
	);

	pgwr_seq seq_i (
		.clk_i, .rst_ni,
		.cmd  (cmd_if.seq),
		.beat (beat_if.seq),
		.tbl_update_done, .free_head, .free_tail, .uncomp_head, .uncomp_tail
	);

	pgwr_axi_wr_port axi_wr_port_i (
		.clk_i, .rst_ni,
		.beat (beat_if.port),
		.awvalid, .awready, .awaddr, .wvalid, .wready, .wdata, .wstrb,
		.bvalid, .bresp, .bus_error
	);

endmodule

// ==== tb_pgwr_top.sv ====
// self-checking testbench, commands and expected beats come from pgwr_cases.txt
// must run from the project root; memory side answers every AW, bready assumed high
// the SLVERR case has to be last, its command never drains
`timescale 1ns/1ps

module tb_pgwr_top
	import pgwr_cfg_pkg::*;
	import pgwr_tbl_pkg::*;
();

	localparam int CLK_PERIOD = 100;
	localparam int WR_BUDGET  = 200; // cycles per expected write

	typedef struct packed {
		cmd_kind_t  kind;
		att_id_t    att;
		lst_id_t    tol;
		list_sel_t  src;
		list_sel_t  dst;
		way_t       way;
		lst_id_t    prev;
		lst_id_t    next;
		logic       slverr;      // first response of the command
		logic [7:0] n_wr;
		lst_id_t    free_head;   // expected afterwards
		lst_id_t    free_tail;
		lst_id_t    uncomp_head;
		lst_id_t    uncomp_tail;
		logic [2:0] flags;       // att done, list done, bus error
	} case_t;

	logic       clk_i;
	logic       rst_ni;
	logic       init_att;
	logic       init_list;
	logic       tbl_update;
	att_id_t    att_entry_id;
	lst_id_t    tol_entry_id;
	list_sel_t  src_list;
	list_sel_t  dst_list;
	way_t       lst_way;
	lst_id_t    lst_prev;
	lst_id_t    lst_next;
	logic       awvalid;
	logic       awready;
	addr_t      awaddr;
	logic       wvalid;
	logic       wready;
	line_t      wdata;
	strb_t      wstrb;
	logic       bvalid;
	logic [1:0] bresp;
	logic       init_att_done;
	logic       init_list_done;
	logic       mngr_ready;
	logic       tbl_update_done;
	logic       bus_error;
	lst_id_t    free_head;
	lst_id_t    free_tail;
	lst_id_t    uncomp_head;
	lst_id_t    uncomp_tail;

	case_t       cases[$];
	addr_t       exp_addr[$];
	line_t       exp_data[$];
	strb_t       exp_strb[$];
	int          errors    = 0;
	int          w_seen    = 0;  // W beats seen so far
	int          w_end     = 0;  // beats expected up to the current command
	int          err_aw    = -1; // AW index answered with SLVERR
	logic        loaded    = 1'b0;
	logic [31:0] lcg_state = 32'd3;
	int          cycle     = 0;
	int          last_due  = -1;
	int          aw_cnt    = 0;
	int          resp_due[$];
	logic [1:0]  resp_code[$];

	pgwr_top pgwr_top_i (.*);

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state;
	endfunction

	task automatic compare(input string name, input logic [511:0] got,
		input logic [511:0] exp);
		if (got !== exp) begin
			errors++;
			$display("[FAIL] t=%0t %s: got %0h, expected %0h", $time, name, got, exp);
		end
	endtask

	task automatic load_cases();
		int           fd;
		string        line;
		string        rest;
		case_t        cur;
		int           kind;
		int           off;
		int           nb;
		lst_id_t      id_a;
		lst_id_t      id_b;
		lst_id_t      id_c;
		lst_id_t      id_d;
		logic [39:0]  way;
		logic [2:0]   flags;
		int           src;
		int           dst;
		int           err;
		addr_t        a;
		logic [127:0] val; // strobed bytes, lowest at the offset
		cur = '0;
		fd = $fopen("pgwr_cases.txt", "r");
		if (fd == 0) begin
			errors++;
			$display("cannot open pgwr_cases.txt, nothing to run");
		end else begin
			while ($fgets(line, fd) > 0) begin
				rest = line.substr(1, line.len() - 1);
				case (line.getc(0))
					"C": begin // kind att tol src dst way prev next slverr
						void'($sscanf(rest, "%d %d %d %d %d %h %d %d %d",
							kind, id_a, id_b, src, dst, way, id_c, id_d, err));
						cur        = '0;
						cur.kind   = cmd_kind_t'(kind);
						cur.att    = att_id_t'(id_a);
						cur.tol    = id_b;
						cur.src    = list_sel_t'(src);
						cur.dst    = list_sel_t'(dst);
						cur.way    = way;
						cur.prev   = id_c;
						cur.next   = id_d;
						cur.slverr = (err != 0);
					end
					"W": begin
						void'($sscanf(rest, "%h %d %d %h", a, off, nb, val));
						val = val & ((128'd1 << (nb * 8)) - 128'd1);
						exp_addr.push_back(a);
						exp_data.push_back(line_t'(val) << (off * 8));
						exp_strb.push_back(((strb_t'(1) << nb) - strb_t'(1)) << off);
						cur.n_wr = cur.n_wr + 1'b1;
					end
					"S": begin // closes the command
						void'($sscanf(rest, "%d %d %d %d %b", id_a, id_b, id_c, id_d, flags));
						cur.free_head   = id_a;
						cur.free_tail   = id_b;
						cur.uncomp_head = id_c;
						cur.uncomp_tail = id_d;
						cur.flags       = flags;
						cases.push_back(cur);
					end
					default: ; // comments, blank lines
				endcase
			end
			$fclose(fd);
		end
	endtask

	task automatic run_case(input case_t c);
		logic done;
		w_end = w_end + int'(c.n_wr);
		if (c.slverr) err_aw = w_end - int'(c.n_wr);
		@(posedge clk_i);
		if (c.kind == CMD_ATT_INIT) begin
			init_att <= 1'b1; // level, left high
		end else if (c.kind == CMD_LIST_INIT) begin
			init_list <= 1'b1;
		end else begin
			att_entry_id <= c.att;
			tol_entry_id <= c.tol;
			src_list     <= c.src;
			dst_list     <= c.dst;
			lst_way      <= c.way;
			lst_prev     <= c.prev;
			lst_next     <= c.next;
			tbl_update   <= 1'b1;
			@(posedge clk_i);
			tbl_update   <= 1'b0;
		end
		if (c.slverr) begin
			// SLVERR keeps one response pending, so no finish
			do begin
				@(posedge clk_i);
			end while (!(bus_error && w_seen == w_end));
			repeat (20) @(posedge clk_i); // flag must hold
		end else begin
			do begin
				@(posedge clk_i);
				case (c.kind)
					CMD_ATT_INIT:  done = init_att_done;
					CMD_LIST_INIT: done = init_list_done;
					default:       done = tbl_update_done; // one-cycle pulse
				endcase
			end while (!done);
			@(posedge clk_i);
			compare("mngr_ready", mngr_ready, 1'b1);
		end
		compare("beat count", w_seen, w_end);
		compare("free_head", free_head, c.free_head);
		compare("free_tail", free_tail, c.free_tail);
		compare("uncomp_head", uncomp_head, c.uncomp_head);
		compare("uncomp_tail", uncomp_tail, c.uncomp_tail);
		compare("init_att_done", init_att_done, c.flags[2]);
		compare("init_list_done", init_list_done, c.flags[1]);
		compare("bus_error", bus_error, c.flags[0]);
	endtask

	initial begin
		clk_i = 1'b0;
		forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
	end

	// memory side: random ready, in-order responses after a random delay
	always @(posedge clk_i) begin : mem_side
		logic [31:0] r;
		int          due;
		if (!rst_ni) begin
			awready <= 1'b0;
			wready  <= 1'b0;
			bvalid  <= 1'b0;
			bresp   <= 2'b00;
		end else begin
			r = lcg_next();
			awready <= (r[31:30] != 2'b00); // ready about 3 of 4 cycles
			wready  <= (r[29:28] != 2'b00);
			if (awvalid && awready) begin
				due = cycle + int'(r[27:23]); // up to 31 cycles late
				if (due <= last_due) due = last_due + 1;
				last_due = due;
				resp_due.push_back(due);
				resp_code.push_back((aw_cnt == err_aw) ? 2'b10 : 2'b00);
				aw_cnt++;
			end
			if (resp_due.size() != 0 && resp_due[0] <= cycle) begin
				bvalid <= 1'b1;
				bresp  <= resp_code.pop_front();
				void'(resp_due.pop_front());
			end else begin
				bvalid <= 1'b0;
				bresp  <= 2'b00;
			end
			cycle++;
		end
	end

	// every W handshake against the next expected beat
	always @(posedge clk_i) begin : w_monitor
		if (rst_ni && wvalid && wready) begin
			if (w_seen < exp_addr.size()) begin
				compare("awaddr", awaddr, exp_addr[w_seen]);
				compare("wdata", wdata, exp_data[w_seen]);
				compare("wstrb", wstrb, exp_strb[w_seen]);
			end else begin
				errors++;
				$display("write to %0h at %0t was not expected", awaddr, $time);
			end
			w_seen++;
		end
	end

	initial begin : main
		rst_ni       = 1'b0;
		init_att     = 1'b0;
		init_list    = 1'b0;
		tbl_update   = 1'b0;
		att_entry_id = '0;
		tol_entry_id = '0;
		src_list     = FREE;
		dst_list     = FREE;
		lst_way      = '0;
		lst_prev     = '0;
		lst_next     = '0;
		awready      = 1'b0;
		wready       = 1'b0;
		bvalid       = 1'b0;
		bresp        = 2'b00;
		load_cases();
		loaded = 1'b1;
		repeat (5) @(posedge clk_i);
		compare("mngr_ready", mngr_ready, 1'b1); // reset state
		compare("awvalid", awvalid, 1'b0);
		compare("wvalid", wvalid, 1'b0);
		compare("bus_error", bus_error, 1'b0);
		compare("free_head", free_head, '0);
		compare("uncomp_tail", uncomp_tail, '0);
		rst_ni <= 1'b1;
		foreach (cases[i]) run_case(cases[i]);
		compare("total beats", w_seen, exp_addr.size());
		$display("errors: %0d, beats seen: %0d of %0d", errors, w_seen, exp_addr.size());
		if (errors == 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

	initial begin : watchdog
		wait (loaded);
		#((exp_addr.size() * WR_BUDGET + 50) * CLK_PERIOD);
		$display("timeout, run took too long with %0d of %0d beats seen",
			w_seen, exp_addr.size());
		$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

// ==== pgwr_cases.txt ====
# C kind att_id tol_id src dst way(hex) prev next slverr  (kind 1 ATT init, 2 list init, 3 update)
# W addr(hex) byte_offset byte_count value(hex, strobed bytes, lowest byte at the offset)
# S free_head free_tail uncomp_head uncomp_tail flags(att_done list_done bus_error)
C 1 0 0 0 0 0 0 0 0
W 80000000 0 8 0
W 80000000 8 8 0
W 80000000 16 8 0
W 80000000 24 8 0
W 80000000 32 8 0
W 80000000 40 8 0
W 80000000 48 8 0
W 80000000 56 8 0
W 80000040 0 8 0
W 80000040 8 8 0
W 80000040 16 8 0
W 80000040 24 8 0
W 80000040 32 8 0
W 80000040 40 8 0
W 80000040 48 8 0
W 80000040 56 8 0
S 0 0 0 0 100
C 2 0 0 0 0 0 0 0 0
W 80001000 0 16 00000801000000000000000002
W 80001000 16 16 00000801010000000100000003
W 80001000 32 16 00000801020000000200000004
W 80001000 48 16 00000801030000000300000005
W 80001040 0 16 00000801040000000400000006
W 80001040 16 16 00000801050000000500000007
W 80001040 32 16 00000801060000000600000008
W 80001040 48 16 00000801070000000700000000
S 1 8 0 0 110
# entry 1 into the empty uncompressed list
C 3 3 1 0 1 80100 0 2 0
W 80000000 16 8 0000000000200401
W 80001000 20 4 00000000
W 80001000 0 8 0000000000000000
S 2 8 1 1 110
# entry 2 behind entry 1, link write on the old tail
C 3 7 2 0 1 80101 0 3 0
W 80000000 48 8 0000000000200405
W 80001000 36 4 00000000
W 80001000 16 8 0000000100000000
W 80001000 0 4 00000002
S 3 8 1 2 110
# entry 3, first response SLVERR
C 3 12 3 0 1 80102 0 4 1
W 80000040 24 8 0000000000200409
W 80001000 52 4 00000000
W 80001000 32 8 0000000200000000
W 80001000 16 4 00000003
S 4 8 1 3 111

// ==== sources.f ====
pgwr_cfg_pkg.sv
pgwr_tbl_pkg.sv
pgwr_cmd_if.sv
pgwr_beat_if.sv
pgwr_cmd_intake.sv
pgwr_line_builder.sv
pgwr_seq.sv
pgwr_axi_wr_port.sv
pgwr_top.sv
tb_pgwr_top.sv

// ==== Makefile ====
# Verilator build and run of the page-table write manager testbench
VERILATOR ?= verilator
TOP       ?= tb_pgwr_top
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
FAIL_MSG  ?= Simulation finished: FAIL
PASS_MSG  ?= Simulation finished: PASS

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "run failed, see $(LOG)"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "no pass message in $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)
